//--- filelist.f
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
test/clock_gen.sv
test/rename_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rename core testbench with Verilator
# exits non-zero unless the simulation log reports a pass

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
pass_text="Result: PASSED"

rm -rf "$build_dir" "$log_file"

verilator --binary --timing --assert \
  --top-module rename_core_tb \
  --Mdir "$build_dir" \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vrename_core_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "$pass_text" "$log_file"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- test/clock_gen.sv
// testbench clock and reset
// 20 ns clock, reset held high for the first 10 rising edges

`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 10;

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  // release lines up with the 2 ns input skew of the testbench
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
  end

endmodule

//--- test/rename_core_tb.sv
// rename core testbench
// random dispatch, completion and mispredict traffic checked against a
// model of credits, register map, free registers and in-flight entries

`timescale 1ns/1ps

module rename_core_tb;

  import rename_pkg::*;

  localparam int OPS = 400;
  localparam int WATCHDOG_NS = OPS * 30 * 20;

  typedef struct packed {
    rob_idx_t idx;
    logic complete;
    arch_reg_t dest;
    phys_reg_t t;
    phys_reg_t t_old;
  } inflight_t;

  // dispatch still waiting for its registered result
  typedef struct packed {
    logic valid;
    rob_idx_t idx;
    arch_reg_t dest;
    phys_reg_t t_old;
    logic [NUM_PR-1:0] free_snap;
  } pending_t;

  logic clock;
  logic reset;
  dispatch_t dispatch;
  logic complete_valid;
  rob_idx_t complete_idx;
  mispredict_t mispredict;
  rename_result_t rename_result;
  retire_t retire;
  logic credit_return;
  logic walk_busy;

  inflight_t rob_q [$];
  pending_t pend;
  phys_reg_t model_map [NUM_ARCH];
  logic [NUM_PR-1:0] free_mask;
  rob_idx_t model_tail;
  int credits;
  int walk_left;
  logic [15:0] lfsr;
  int errors;
  int checks;

  clock_gen clk0 (
    .clock (clock),
    .reset (reset)
  );

  rename_core dut0 (
    .clock          (clock),
    .reset          (reset),
    .dispatch       (dispatch),
    .complete_valid (complete_valid),
    .complete_idx   (complete_idx),
    .mispredict     (mispredict),
    .rename_result  (rename_result),
    .retire         (retire),
    .credit_return  (credit_return),
    .walk_busy      (walk_busy)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic int random_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return value;
  endfunction

  function automatic logic is_mapped(input phys_reg_t p);
    logic found;
    found = 1'b0;
    for (int i = 0; i < NUM_ARCH; i++) begin
      if (model_map[i] == p) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  function automatic int find_entry(input rob_idx_t idx);
    int pos;
    pos = -1;
    for (int i = 0; i < rob_q.size(); i++) begin
      if (rob_q[i].idx == idx) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  task automatic compare_value(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error %0t ns: %s", $time, what);
    end
  endtask

  task automatic drive_inputs(input logic traffic);
    int open_list [$];
    int pick;
    dispatch = '0;
    complete_valid = 1'b0;
    complete_idx = '0;
    mispredict = '0;
    // entries still queued for the walk are not offered for completion
    for (int i = 0; i < rob_q.size() - walk_left; i++) begin
      if (!rob_q[i].complete) begin
        open_list.push_back(i);
      end
    end
    if (traffic && walk_left == 0) begin
      if (rob_q.size() > 0 && random_bits(5) == 0) begin
        pick = random_bits(4) % rob_q.size();
        mispredict.valid = 1'b1;
        mispredict.branch_idx = rob_q[pick].idx;
      end
      if (credits > 0 && random_bits(2) != 0) begin
        dispatch.valid = 1'b1;
        dispatch.dest = arch_reg_t'(random_bits(3));
      end
    end
    // completion stays off in a mispredict cycle
    if (!mispredict.valid && open_list.size() > 0) begin
      if (!traffic) begin
        complete_valid = 1'b1;
        complete_idx = rob_q[open_list[0]].idx;
      end else if (random_bits(1) == 1) begin
        pick = random_bits(4) % open_list.size();
        complete_valid = 1'b1;
        complete_idx = rob_q[open_list[pick]].idx;
      end
    end
  endtask

  task automatic observe_cycle();
    inflight_t entry;
    int pos;
    logic retire_exp;
    logic walk_exp;
    // result of the previous cycle's dispatch
    compare_value("rename_result.valid", int'(rename_result.valid), int'(pend.valid));
    if (pend.valid && rename_result.valid) begin
      compare_value("rename_result.rob_idx", int'(rename_result.rob_idx), int'(pend.idx));
      compare_value("rename_result.t_old", int'(rename_result.t_old), int'(pend.t_old));
      require(pend.free_snap[rename_result.t], "rename result T was not a free register");
      require(!is_mapped(rename_result.t), "rename result T is still mapped");
      model_map[pend.dest] = rename_result.t;
      free_mask[rename_result.t] = 1'b0;
      entry = rob_q[rob_q.size() - 1];
      entry.t = rename_result.t;
      rob_q[rob_q.size() - 1] = entry;
    end
    pend.valid = 1'b0;
    if (dispatch.valid) begin
      pend.valid = 1'b1;
      pend.idx = model_tail;
      pend.dest = dispatch.dest;
      pend.t_old = model_map[dispatch.dest];
      pend.free_snap = free_mask;
      entry = '0;
      entry.idx = model_tail;
      entry.dest = dispatch.dest;
      entry.t_old = model_map[dispatch.dest];
      rob_q.push_back(entry);
      model_tail = model_tail + rob_idx_t'(1);
      credits = credits - 1;
    end
    walk_exp = (walk_left > 0);
    retire_exp = !walk_exp && rob_q.size() > 0 && rob_q[0].complete;
    compare_value("retire.valid", int'(retire.valid), int'(retire_exp));
    compare_value("walk_busy", int'(walk_busy), int'(walk_exp));
    compare_value("credit_return", int'(credit_return), int'(retire_exp | walk_exp));
    // the dispatcher only regains credits through the returned pulses
    if (credit_return) begin
      credits = credits + 1;
    end
    if (retire_exp) begin
      entry = rob_q.pop_front();
      compare_value("retire.dest", int'(retire.dest), int'(entry.dest));
      compare_value("retire.t", int'(retire.t), int'(entry.t));
      compare_value("retire.t_old", int'(retire.t_old), int'(entry.t_old));
      free_mask[entry.t_old] = 1'b1;
    end
    if (walk_exp) begin
      // youngest entry is squashed and its mapping rolls back
      entry = rob_q.pop_back();
      model_map[entry.dest] = entry.t_old;
      free_mask[entry.t] = 1'b1;
      model_tail = model_tail - rob_idx_t'(1);
      walk_left = walk_left - 1;
    end
    require(credits >= 0 && credits <= NUM_ROB, "credit count left the range 0 to NUM_ROB");
    if (complete_valid) begin
      pos = find_entry(complete_idx);
      if (pos >= 0) begin
        entry = rob_q[pos];
        entry.complete = 1'b1;
        rob_q[pos] = entry;
      end
    end
    if (mispredict.valid) begin
      pos = find_entry(mispredict.branch_idx);
      // a branch that retired this cycle leaves every remaining entry younger
      walk_left = (pos < 0) ? rob_q.size() : rob_q.size() - 1 - pos;
    end
  endtask

  task automatic run_cycle(input logic traffic);
    @(posedge clock);
    #2;
    drive_inputs(traffic);
    @(negedge clock);
    observe_cycle();
  endtask

  initial begin
    dispatch = '0;
    complete_valid = 1'b0;
    complete_idx = '0;
    mispredict = '0;
    lfsr = 16'd22358;
    errors = 0;
    checks = 0;
    credits = NUM_ROB;
    walk_left = 0;
    model_tail = '0;
    pend = '0;
    free_mask = '0;
    for (int i = 0; i < NUM_ARCH; i++) begin
      model_map[i] = phys_reg_t'(i);
    end
    for (int i = NUM_ARCH; i < NUM_PR; i++) begin
      free_mask[i] = 1'b1;
    end
    // outputs stay quiet through reset and the cycle right after it
    do begin
      @(negedge clock);
      compare_value("rename_result.valid", int'(rename_result.valid), 0);
      compare_value("retire.valid", int'(retire.valid), 0);
      compare_value("credit_return", int'(credit_return), 0);
      compare_value("walk_busy", int'(walk_busy), 0);
      if (credit_return) begin
        credits = credits + 1;
      end
    end while (reset);
    compare_value("credits", credits, NUM_ROB);
    for (int op = 0; op < OPS; op++) begin
      run_cycle(1'b1);
    end
    // drain with completions only, then one idle cycle
    while (rob_q.size() > 0 || walk_left > 0 || pend.valid) begin
      run_cycle(1'b0);
    end
    run_cycle(1'b0);
    compare_value("credits", credits, NUM_ROB);
    compare_value("free registers", $countones(free_mask), FREE_DEPTH);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with traffic still running", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog/free_list.sv
// free physical register list
// circular FIFO preloaded with the registers above the architectural set

`timescale 1ns/1ps

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pop,
  input  logic                  push,
  input  rename_pkg::phys_reg_t push_reg,
  output rename_pkg::phys_reg_t head_reg
);

  import rename_pkg::*;

  phys_reg_t slots [FREE_DEPTH];
  free_ptr_t rd_ptr;
  free_ptr_t wr_ptr;

  // oldest free register, consumed by the next dispatch
  assign head_reg = slots[rd_ptr];

  // read pointer advances on pop
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + free_ptr_t'(1);
    end
  end

  // list starts full, so the write pointer wraps to match the read pointer
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + free_ptr_t'(1);
    end
  end

  // preload NUM_ARCH .. NUM_PR-1 in order
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < FREE_DEPTH; i++) begin
        slots[i] <= phys_reg_t'(NUM_ARCH + i);
      end
    end else if (push) begin
      // occupancy never exceeds FREE_DEPTH, so this slot was already popped
      slots[wr_ptr] <= push_reg;
    end
  end

endmodule

//--- verilog/map_table.sv
// speculative register map
// architectural to physical mapping, combinational read,
// written at dispatch and restored entry by entry during a walk

`timescale 1ns/1ps

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  rename_pkg::arch_reg_t read_arch,
  output rename_pkg::phys_reg_t read_phys,
  input  logic                  write_en,
  input  rename_pkg::arch_reg_t write_arch,
  input  rename_pkg::phys_reg_t write_phys
);

  import rename_pkg::*;

  phys_reg_t map [NUM_ARCH];

  // current mapping, the T_old of a dispatch this cycle
  assign read_phys = map[read_arch];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping out of reset
      for (int i = 0; i < NUM_ARCH; i++) begin
        map[i] <= phys_reg_t'(i);
      end
    end else if (write_en) begin
      map[write_arch] <= write_phys;
    end
  end

endmodule

//--- verilog/rename_core.sv
// register rename core
// ties the reorder buffer to the free list and map table and returns
// one dispatch credit per retired or squashed entry

`timescale 1ns/1ps

module rename_core (
  input  logic                       clock,
  input  logic                       reset,
  input  rename_pkg::dispatch_t      dispatch,
  input  logic                       complete_valid,
  input  rename_pkg::rob_idx_t       complete_idx,
  input  rename_pkg::mispredict_t    mispredict,
  output rename_pkg::rename_result_t rename_result,
  output rename_pkg::retire_t        retire,
  output logic                       credit_return,
  output logic                       walk_busy
);

  import rename_pkg::*;

  logic alloc;
  logic map_write;
  logic free_push;
  logic squash;
  phys_reg_t free_reg;
  phys_reg_t map_old;
  phys_reg_t map_phys;
  phys_reg_t free_reg_in;
  arch_reg_t map_arch;

  reorder_buffer rob0 (
    .clock          (clock),
    .reset          (reset),
    .dispatch       (dispatch),
    .complete_valid (complete_valid),
    .complete_idx   (complete_idx),
    .mispredict     (mispredict),
    .free_reg       (free_reg),
    .map_old        (map_old),
    .alloc          (alloc),
    .map_write      (map_write),
    .map_arch       (map_arch),
    .map_phys       (map_phys),
    .free_push      (free_push),
    .free_reg_in    (free_reg_in),
    .squash         (squash),
    .rename_result  (rename_result),
    .retire         (retire),
    .walk_busy      (walk_busy)
  );

  free_list free0 (
    .clock    (clock),
    .reset    (reset),
    .pop      (alloc),
    .push     (free_push),
    .push_reg (free_reg_in),
    .head_reg (free_reg)
  );

  // read port looks up the dispatched destination
  map_table map0 (
    .clock      (clock),
    .reset      (reset),
    .read_arch  (dispatch.dest),
    .read_phys  (map_old),
    .write_en   (map_write),
    .write_arch (map_arch),
    .write_phys (map_phys)
  );

  // retire and squash never fall in the same cycle
  assign credit_return = retire.valid | squash;

endmodule

//--- verilog/rename_pkg.sv
// rename core shared definitions
// sizes, register and index types, the dispatch/retire structs
// and the reorder buffer walk state

package rename_pkg;

  // architectural registers visible to software
  localparam int NUM_ARCH = 8;
  // in-flight instruction window
  localparam int NUM_ROB = 16;
  // physical register file size
  localparam int NUM_PR = 24;
  // registers not holding an architectural value after reset
  // equal to NUM_ROB, so a held credit always finds a free register
  localparam int FREE_DEPTH = NUM_PR - NUM_ARCH;

  typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;
  typedef logic [$clog2(NUM_PR)-1:0] phys_reg_t;
  typedef logic [$clog2(NUM_ROB)-1:0] rob_idx_t;
  typedef logic [$clog2(FREE_DEPTH)-1:0] free_ptr_t;

  typedef struct packed {
    logic valid;
    arch_reg_t dest;
  } dispatch_t;

  typedef struct packed {
    logic valid;
    rob_idx_t rob_idx;
    phys_reg_t t;
    phys_reg_t t_old;
  } rename_result_t;

  typedef struct packed {
    logic valid;
    logic complete;
    arch_reg_t dest;
    phys_reg_t t;
    phys_reg_t t_old;
  } rob_entry_t;

  typedef struct packed {
    logic valid;
    arch_reg_t dest;
    phys_reg_t t;
    phys_reg_t t_old;
  } retire_t;

  typedef struct packed {
    logic valid;
    rob_idx_t branch_idx;
  } mispredict_t;

  typedef enum logic {
    normal,
    walking
  } rob_mode_t;

endpackage

//--- verilog/reorder_buffer.sv
// reorder buffer
// tracks in-flight renamed instructions, retires the head in order
// and walks the tail back one entry per cycle after a mispredict

`timescale 1ns/1ps

module reorder_buffer (
  input  logic                       clock,
  input  logic                       reset,
  input  rename_pkg::dispatch_t      dispatch,
  input  logic                       complete_valid,
  input  rename_pkg::rob_idx_t       complete_idx,
  input  rename_pkg::mispredict_t    mispredict,
  input  rename_pkg::phys_reg_t      free_reg,
  input  rename_pkg::phys_reg_t      map_old,
  output logic                       alloc,
  output logic                       map_write,
  output rename_pkg::arch_reg_t      map_arch,
  output rename_pkg::phys_reg_t      map_phys,
  output logic                       free_push,
  output rename_pkg::phys_reg_t      free_reg_in,
  output logic                       squash,
  output rename_pkg::rename_result_t rename_result,
  output rename_pkg::retire_t        retire,
  output logic                       walk_busy
);

  import rename_pkg::*;

  rob_entry_t entries [NUM_ROB];
  rob_idx_t head;
  rob_idx_t tail;
  rob_idx_t tail_next;
  rob_idx_t step_idx;
  rob_idx_t walk_target;
  rob_idx_t walk_stop;
  rob_mode_t mode;
  logic retire_now;

  // registered rename result
  logic result_valid;
  rob_idx_t result_idx;
  phys_reg_t result_t;
  phys_reg_t result_t_old;

  always_comb begin
    // head leaves once complete, but never during a walk
    retire_now = (mode == normal) && entries[head].valid && entries[head].complete;
    // entry squashed this cycle while walking
    step_idx = tail - rob_idx_t'(1);
    tail_next = dispatch.valid ? tail + rob_idx_t'(1) : tail;
    // the walk stops once the tail sits just past the branch
    walk_target = mispredict.branch_idx + rob_idx_t'(1);
  end

  assign alloc = dispatch.valid;
  assign walk_busy = (mode == walking);
  assign squash = walk_busy;

  // map write: restore during the walk, new mapping at dispatch
  always_comb begin
    if (walk_busy) begin
      map_write = 1'b1;
      map_arch = entries[step_idx].dest;
      map_phys = entries[step_idx].t_old;
    end else begin
      map_write = dispatch.valid;
      map_arch = dispatch.dest;
      map_phys = free_reg;
    end
  end

  // squashed T or retired T_old goes back to the free list
  always_comb begin
    free_push = walk_busy | retire_now;
    free_reg_in = walk_busy ? entries[step_idx].t : entries[head].t_old;
  end

  always_comb begin
    retire.valid = retire_now;
    retire.dest = entries[head].dest;
    retire.t = entries[head].t;
    retire.t_old = entries[head].t_old;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      mode <= normal;
      for (int i = 0; i < NUM_ROB; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      if (dispatch.valid) begin
        entries[tail].valid <= 1'b1;
        entries[tail].complete <= 1'b0;
        entries[tail].dest <= dispatch.dest;
        entries[tail].t <= free_reg;
        entries[tail].t_old <= map_old;
      end

      if (complete_valid && entries[complete_idx].valid) begin
        entries[complete_idx].complete <= 1'b1;
      end

      if (retire_now) begin
        entries[head].valid <= 1'b0;
        head <= head + rob_idx_t'(1);
      end

      case (mode)
        normal: begin
          tail <= tail_next;
          // a dispatch in the mispredict cycle is younger and gets squashed too
          if (mispredict.valid && (tail_next != walk_target)) begin
            mode <= walking;
          end
        end
        walking: begin
          entries[step_idx].valid <= 1'b0;
          tail <= step_idx;
          if (step_idx == walk_stop) begin
            mode <= normal;
          end
        end
        default: mode <= normal;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (mispredict.valid && (mode == normal)) begin
      walk_stop <= walk_target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= dispatch.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch.valid) begin
      result_idx <= tail;
      result_t <= free_reg;
      result_t_old <= map_old;
    end
  end

  always_comb begin
    rename_result.valid = result_valid;
    rename_result.rob_idx = result_idx;
    rename_result.t = result_t;
    rename_result.t_old = result_t_old;
  end

endmodule
